// File: source/conv_pkg.sv
package conv_pkg;

  // Frame geometry.
  localparam int FRAME_ROWS = 7;
  localparam int FRAME_COLS = 7;
  localparam int WIN        = 5;
  localparam int TAPS       = WIN * WIN;

  // Datapath widths.
  localparam int PIX_W  = 8;
  localparam int COEF_W = 8;
  localparam int ACC_W  = 21;
  localparam int ADDR_W = 6;
  localparam int IDX_W  = 5;
  localparam int CNT_W  = 3;

  // Fetch sequencing, two filler columns per row.
  localparam int FETCH_COLS = FRAME_COLS + 2;
  localparam int FCOL_W     = 4;

  // Cycles from a fetch until its column sits at dx of 4.
  localparam int FILL_DEPTH = 2;

  // Controller states.
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_FETCH = 2'd1;
  localparam logic [1:0] ST_DRAIN = 2'd2;

endpackage

// File: source/frame_mem.sv
`timescale 1ns/1ps

module frame_mem import conv_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_pix_we,
  input  logic [ADDR_W-1:0] i_pix_addr,
  input  logic [PIX_W-1:0]  i_pix_data,
  input  logic              i_fetch_en,
  input  logic [CNT_W-1:0]  i_fetch_row,
  input  logic [FCOL_W-1:0] i_fetch_col,
  output logic [PIX_W-1:0]  o_col_pix0,
  output logic [PIX_W-1:0]  o_col_pix1,
  output logic [PIX_W-1:0]  o_col_pix2,
  output logic [PIX_W-1:0]  o_col_pix3,
  output logic [PIX_W-1:0]  o_col_pix4
);

  logic [PIX_W-1:0] mem [FRAME_ROWS*FRAME_COLS];
  logic [PIX_W-1:0] rd_q [WIN];
  logic             col_in;

  always_ff @(posedge clk) begin
    if (i_pix_we) begin
      mem[i_pix_addr] <= i_pix_data;
    end
  end

  assign col_in = (i_fetch_col < FCOL_W'(FRAME_COLS));

  // One read lane per window row, row r+dy-2.
  for (genvar dy = 0; dy < WIN; dy++) begin : g_lane
    logic [CNT_W:0]  src_row;
    logic            row_in;
    logic [ADDR_W-1:0] rd_addr;

    assign src_row = {1'b0, i_fetch_row} + (CNT_W+1)'(dy);
    assign row_in  = (src_row >= 2) && (src_row < FRAME_ROWS + 2);
    assign rd_addr = ADDR_W'((src_row - 2) * FRAME_COLS + i_fetch_col);

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rd_q[dy] <= '0;
      end else if (i_fetch_en) begin
        rd_q[dy] <= (row_in && col_in) ? mem[rd_addr] : '0;
      end
    end
  end

  assign o_col_pix0 = rd_q[0];
  assign o_col_pix1 = rd_q[1];
  assign o_col_pix2 = rd_q[2];
  assign o_col_pix3 = rd_q[3];
  assign o_col_pix4 = rd_q[4];

  a_pix_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    i_pix_we |-> i_pix_addr < ADDR_W'(FRAME_ROWS * FRAME_COLS))
    else $error("pixel write address out of frame");

endmodule

// File: source/coef_bank.sv
`timescale 1ns/1ps

module coef_bank import conv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_coef_we,
  input  logic [IDX_W-1:0]       i_coef_idx,
  input  logic [COEF_W-1:0]      i_coef_data,
  output logic [TAPS*COEF_W-1:0] o_coef_flat
);

  logic [TAPS-1:0][COEF_W-1:0] coef_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_q <= '0;
    end else if (i_coef_we) begin
      coef_q[i_coef_idx] <= i_coef_data;
    end
  end

  // Tap t sits at bits t*COEF_W upward.
  assign o_coef_flat = coef_q;

  a_coef_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
    i_coef_we |-> i_coef_idx < IDX_W'(TAPS))
    else $error("coefficient index out of range");

endmodule

// File: source/window_ctrl.sv
`timescale 1ns/1ps

module window_ctrl import conv_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_start,
  input  logic              i_done,
  output logic              o_busy,
  output logic              o_fetch_en,
  output logic [CNT_W-1:0]  o_fetch_row,
  output logic [FCOL_W-1:0] o_fetch_col,
  output logic              o_win_en
);

  logic [1:0]            state_q;
  logic [CNT_W-1:0]      row_q;
  logic [FCOL_W-1:0]     col_q;
  logic [FILL_DEPTH-1:0] win_pipe_q;
  logic                  col_last;
  logic                  row_last;

  assign col_last = (col_q == FCOL_W'(FETCH_COLS - 1));
  assign row_last = (row_q == CNT_W'(FRAME_ROWS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      row_q   <= '0;
      col_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (i_start) begin
            state_q <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          if (col_last) begin
            col_q <= '0;
            row_q <= row_last ? '0 : row_q + 1'b1;
            if (row_last) begin
              state_q <= ST_DRAIN;
            end
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        ST_DRAIN: begin
          // Wait for the last result to leave the MAC.
          if (i_done) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Only fetches of k >= 2 complete a window.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_pipe_q <= '0;
    end else begin
      win_pipe_q <= {win_pipe_q[FILL_DEPTH-2:0], o_fetch_en && (col_q >= FCOL_W'(WIN / 2))};
    end
  end

  assign o_busy      = (state_q != ST_IDLE);
  assign o_fetch_en  = (state_q == ST_FETCH);
  assign o_fetch_row = row_q;
  assign o_fetch_col = col_q;
  assign o_win_en    = win_pipe_q[FILL_DEPTH-1];

  // The MAC finishes a frame only after the last fetch.
  a_done_in_drain: assert property (@(posedge clk) disable iff (!rst_n)
    i_done |-> state_q == ST_DRAIN)
    else $error("frame done outside drain state");

endmodule

// File: source/window_5x5.sv
`timescale 1ns/1ps

module window_5x5 import conv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [PIX_W-1:0]      i_col_pix0,
  input  logic [PIX_W-1:0]      i_col_pix1,
  input  logic [PIX_W-1:0]      i_col_pix2,
  input  logic [PIX_W-1:0]      i_col_pix3,
  input  logic [PIX_W-1:0]      i_col_pix4,
  input  logic                  i_win_en,
  output logic [TAPS*PIX_W-1:0] o_win_flat,
  output logic                  o_win_valid,
  output logic                  o_win_last
);

  logic [PIX_W-1:0] col_pix [WIN];
  logic [PIX_W-1:0] shift_q [WIN][WIN];
  logic [CNT_W-1:0] row_q;
  logic [CNT_W-1:0] col_q;
  logic             row_eq_max;
  logic             col_eq_max;
  logic             row_ok [WIN];
  logic             col_ok [WIN];

  assign col_pix[0] = i_col_pix0;
  assign col_pix[1] = i_col_pix1;
  assign col_pix[2] = i_col_pix2;
  assign col_pix[3] = i_col_pix3;
  assign col_pix[4] = i_col_pix4;

  assign row_eq_max = (row_q == CNT_W'(FRAME_ROWS - 1));
  assign col_eq_max = (col_q == CNT_W'(FRAME_COLS - 1));

  // Output position of the window being registered.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_q <= '0;
    end else if (i_win_en) begin
      col_q <= col_eq_max ? '0 : col_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_q <= '0;
    end else if (i_win_en && col_eq_max) begin
      row_q <= row_q + 1'b1;
    end else if (row_q == CNT_W'(FRAME_ROWS)) begin
      row_q <= '0;
    end
  end

  // Newest column enters at dx of 4.
  always_ff @(posedge clk) begin
    for (int dy = 0; dy < WIN; dy++) begin
      for (int dx = 0; dx < WIN - 1; dx++) begin
        shift_q[dy][dx] <= shift_q[dy][dx+1];
      end
      shift_q[dy][WIN-1] <= col_pix[dy];
    end
  end

  // Border tests per window row and column.
  assign row_ok[0] = !(row_q < 2);
  assign row_ok[1] = !(row_q < 1);
  assign row_ok[2] = 1'b1;
  assign row_ok[3] = !(row_q > FRAME_ROWS - 2);
  assign row_ok[4] = !(row_q > FRAME_ROWS - 3);

  assign col_ok[0] = !(col_q < 2);
  assign col_ok[1] = !(col_q < 1);
  assign col_ok[2] = 1'b1;
  assign col_ok[3] = !(col_q > FRAME_COLS - 2);
  assign col_ok[4] = !(col_q > FRAME_COLS - 3);

  always_ff @(posedge clk) begin
    if (i_win_en) begin
      for (int dy = 0; dy < WIN; dy++) begin
        for (int dx = 0; dx < WIN; dx++) begin
          o_win_flat[(dy*WIN+dx)*PIX_W +: PIX_W] <=
            (row_ok[dy] && col_ok[dx]) ? shift_q[dy][dx] : '0;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_win_valid <= 1'b0;
      o_win_last  <= 1'b0;
    end else begin
      o_win_valid <= i_win_en;
      o_win_last  <= i_win_en && row_eq_max && col_eq_max;
    end
  end

  // Controller must not start a frame while the row counter wraps.
  a_no_win_at_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    i_win_en |-> row_q != CNT_W'(FRAME_ROWS))
    else $error("window strobe during row counter wrap");

endmodule

// File: source/conv_mac.sv
`timescale 1ns/1ps

module conv_mac import conv_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [TAPS*PIX_W-1:0]    i_win_flat,
  input  logic                     i_win_valid,
  input  logic                     i_win_last,
  input  logic [TAPS*COEF_W-1:0]   i_coef_flat,
  output logic signed [ACC_W-1:0]  o_pix,
  output logic                     o_valid,
  output logic                     o_done
);

  logic signed [ACC_W-1:0] prod [TAPS];
  logic signed [ACC_W-1:0] row_sum [WIN];
  logic signed [ACC_W-1:0] row_sum_q [WIN];
  logic signed [ACC_W-1:0] total;
  logic                    valid_q;
  logic                    last_q;

  // Unsigned pixel times signed coefficient.
  for (genvar t = 0; t < TAPS; t++) begin : g_prod
    assign prod[t] = $signed({1'b0, i_win_flat[t*PIX_W +: PIX_W]}) *
                     $signed(i_coef_flat[t*COEF_W +: COEF_W]);
  end

  always_comb begin
    for (int dy = 0; dy < WIN; dy++) begin
      row_sum[dy] = '0;
      for (int dx = 0; dx < WIN; dx++) begin
        row_sum[dy] = row_sum[dy] + prod[dy*WIN+dx];
      end
    end
  end

  always_comb begin
    total = '0;
    for (int dy = 0; dy < WIN; dy++) begin
      total = total + row_sum_q[dy];
    end
  end

  // Stage 1, one sum per window row.
  always_ff @(posedge clk) begin
    if (i_win_valid) begin
      row_sum_q <= row_sum;
    end
  end

  // Stage 2, the full sum.
  always_ff @(posedge clk) begin
    if (valid_q) begin
      o_pix <= total;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      o_valid <= 1'b0;
      o_done  <= 1'b0;
    end else begin
      valid_q <= i_win_valid;
      last_q  <= i_win_valid && i_win_last;
      o_valid <= valid_q;
      o_done  <= last_q;
    end
  end

endmodule

// File: source/conv5x5_top.sv
`timescale 1ns/1ps

module conv5x5_top import conv_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_pix_we,
  input  logic [ADDR_W-1:0]       i_pix_addr,
  input  logic [PIX_W-1:0]        i_pix_data,
  input  logic                    i_coef_we,
  input  logic [IDX_W-1:0]        i_coef_idx,
  input  logic [COEF_W-1:0]       i_coef_data,
  input  logic                    i_start,
  output logic signed [ACC_W-1:0] o_pix,
  output logic                    o_valid,
  output logic                    o_done,
  output logic                    o_busy
);

  logic                   fetch_en;
  logic [CNT_W-1:0]       fetch_row;
  logic [FCOL_W-1:0]      fetch_col;
  logic                   win_en;
  logic [PIX_W-1:0]       col_pix0;
  logic [PIX_W-1:0]       col_pix1;
  logic [PIX_W-1:0]       col_pix2;
  logic [PIX_W-1:0]       col_pix3;
  logic [PIX_W-1:0]       col_pix4;
  logic [TAPS*PIX_W-1:0]  win_flat;
  logic                   win_valid;
  logic                   win_last;
  logic [TAPS*COEF_W-1:0] coef_flat;

  window_ctrl ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .i_done      (o_done),
    .o_busy      (o_busy),
    .o_fetch_en  (fetch_en),
    .o_fetch_row (fetch_row),
    .o_fetch_col (fetch_col),
    .o_win_en    (win_en)
  );

  frame_mem mem_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_pix_we    (i_pix_we),
    .i_pix_addr  (i_pix_addr),
    .i_pix_data  (i_pix_data),
    .i_fetch_en  (fetch_en),
    .i_fetch_row (fetch_row),
    .i_fetch_col (fetch_col),
    .o_col_pix0  (col_pix0),
    .o_col_pix1  (col_pix1),
    .o_col_pix2  (col_pix2),
    .o_col_pix3  (col_pix3),
    .o_col_pix4  (col_pix4)
  );

  coef_bank coef_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_coef_we   (i_coef_we),
    .i_coef_idx  (i_coef_idx),
    .i_coef_data (i_coef_data),
    .o_coef_flat (coef_flat)
  );

  window_5x5 win_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_col_pix0  (col_pix0),
    .i_col_pix1  (col_pix1),
    .i_col_pix2  (col_pix2),
    .i_col_pix3  (col_pix3),
    .i_col_pix4  (col_pix4),
    .i_win_en    (win_en),
    .o_win_flat  (win_flat),
    .o_win_valid (win_valid),
    .o_win_last  (win_last)
  );

  conv_mac mac_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_win_flat  (win_flat),
    .i_win_valid (win_valid),
    .i_win_last  (win_last),
    .i_coef_flat (coef_flat),
    .o_pix       (o_pix),
    .o_valid     (o_valid),
    .o_done      (o_done)
  );

endmodule

// File: testbench/tb_conv5x5.sv
`timescale 1ns/1ps

module tb_conv5x5 import conv_pkg::*; ();

  logic                    clk;
  logic                    rst_n;
  logic                    i_pix_we;
  logic [ADDR_W-1:0]       i_pix_addr;
  logic [PIX_W-1:0]        i_pix_data;
  logic                    i_coef_we;
  logic [IDX_W-1:0]        i_coef_idx;
  logic [COEF_W-1:0]       i_coef_data;
  logic                    i_start;
  logic signed [ACC_W-1:0] o_pix;
  logic                    o_valid;
  logic                    o_done;
  logic                    o_busy;

  logic [COEF_W-1:0] coef_sets [8][TAPS];
  logic [PIX_W-1:0]  frames [4][FRAME_ROWS*FRAME_COLS];
  int                run_frame [16];
  int                run_set [16];
  int                num_sets;
  int                num_frames;
  int                num_runs;
  int                errors = 0;
  int                checks = 0;
  int                cycles = 0;
  int                timeout_limit = 2000;
  bit                load_ok;

  conv5x5_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_pix_we    (i_pix_we),
    .i_pix_addr  (i_pix_addr),
    .i_pix_data  (i_pix_data),
    .i_coef_we   (i_coef_we),
    .i_coef_idx  (i_coef_idx),
    .i_coef_data (i_coef_data),
    .i_start     (i_start),
    .o_pix       (o_pix),
    .o_valid     (o_valid),
    .o_done      (o_done),
    .o_busy      (o_busy)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("timeout: runs not finished within %0d cycles", timeout_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic load_stim(output bit ok);
    int             fd;
    int             n;
    string          line;
    logic [PIX_W-1:0] v;
    ok = 1'b0;
    fd = $fopen("testbench/conv5x5_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open stimulus file testbench/conv5x5_stim.txt");
      return;
    end
    n = $fgets(line, fd);
    n = $fgets(line, fd);
    n = $fscanf(fd, "%d %d %d", num_sets, num_frames, num_runs);
    if (n != 3 || num_sets > 8 || num_frames > 4 || num_runs > 16) begin
      $display("stimulus file has a bad counts line");
      $fclose(fd);
      return;
    end
    ok = 1'b1;
    for (int s = 0; s < num_sets; s++) begin
      for (int t = 0; t < TAPS; t++) begin
        if ($fscanf(fd, "%h", v) != 1) ok = 1'b0;
        coef_sets[s][t] = v;
      end
    end
    for (int f = 0; f < num_frames; f++) begin
      for (int a = 0; a < FRAME_ROWS * FRAME_COLS; a++) begin
        if ($fscanf(fd, "%h", v) != 1) ok = 1'b0;
        frames[f][a] = v;
      end
    end
    for (int r = 0; r < num_runs; r++) begin
      if ($fscanf(fd, "%d %d", run_frame[r], run_set[r]) != 2) ok = 1'b0;
      if (run_frame[r] >= num_frames || run_set[r] >= num_sets) ok = 1'b0;
    end
    $fclose(fd);
    if (!ok) $display("stimulus file is short or names a missing frame or set");
  endtask

  // Sum over the 25 taps, zero outside the frame.
  function automatic int expected_pix(int f, int s, int r, int c);
    int acc;
    int pr;
    int pc;
    acc = 0;
    for (int dy = 0; dy < WIN; dy++) begin
      for (int dx = 0; dx < WIN; dx++) begin
        pr = r + dy - 2;
        pc = c + dx - 2;
        if (pr >= 0 && pr < FRAME_ROWS && pc >= 0 && pc < FRAME_COLS) begin
          acc = acc + int'(frames[f][pr*FRAME_COLS+pc]) *
                int'($signed(coef_sets[s][dy*WIN+dx]));
        end
      end
    end
    return acc;
  endfunction

  task automatic check_bit(input string what, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic write_frame(input int f);
    for (int a = 0; a < FRAME_ROWS * FRAME_COLS; a++) begin
      @(negedge clk);
      i_pix_we   = 1'b1;
      i_pix_addr = ADDR_W'(a);
      i_pix_data = frames[f][a];
    end
    @(negedge clk);
    i_pix_we = 1'b0;
  endtask

  task automatic write_coefs(input int s);
    for (int t = 0; t < TAPS; t++) begin
      @(negedge clk);
      i_coef_we   = 1'b1;
      i_coef_idx  = IDX_W'(t);
      i_coef_data = coef_sets[s][t];
    end
    @(negedge clk);
    i_coef_we = 1'b0;
  endtask

  task automatic run_frame_check(input int f, input int s);
    int cnt;
    int dones;
    int exp_val;
    int got;
    cnt = 0;
    dones = 0;
    @(negedge clk);
    i_start = 1'b1;
    @(negedge clk);
    i_start = 1'b0;
    check_bit("o_busy after start", o_busy, 1'b1);
    while (o_busy === 1'b1) begin
      // Busy drops on the cycle right after o_done.
      if (dones != 0) begin
        check_bit("o_busy cycle after o_done", o_busy, 1'b0);
      end
      if (o_valid === 1'b1) begin
        exp_val = expected_pix(f, s, cnt / FRAME_COLS, cnt % FRAME_COLS);
        got = o_pix;
        checks++;
        if (cnt >= FRAME_ROWS * FRAME_COLS || got != exp_val) begin
          errors++;
          $display("CHECK FAILED at %0t: pixel (%0d,%0d) expected %0d got %0d",
                   $time, cnt / FRAME_COLS, cnt % FRAME_COLS, exp_val, got);
        end
        cnt++;
      end
      if (o_done === 1'b1) begin
        dones++;
        check_bit("o_valid with o_done", o_valid, 1'b1);
        check_bit("o_done on 49th result", cnt == FRAME_ROWS * FRAME_COLS, 1'b1);
      end
      // Extra starts while busy must be ignored.
      i_start = ($urandom_range(0, 5) == 0);
      @(negedge clk);
    end
    i_start = 1'b0;
    check_bit("49 results in run", cnt == FRAME_ROWS * FRAME_COLS, 1'b1);
    check_bit("single o_done pulse", dones == 1, 1'b1);
    check_bit("o_valid after run", o_valid, 1'b0);
    check_bit("o_done after run", o_done, 1'b0);
  endtask

  initial begin
    int loaded;
    int gap;
    rst_n       = 1'b0;
    i_pix_we    = 1'b0;
    i_pix_addr  = '0;
    i_pix_data  = '0;
    i_coef_we   = 1'b0;
    i_coef_idx  = '0;
    i_coef_data = '0;
    i_start     = 1'b0;
    loaded      = -1;
    void'($urandom(32'h2240_2438));
    load_stim(load_ok);
    if (!load_ok) errors++;
    else timeout_limit = num_runs * (FETCH_COLS * FRAME_ROWS + 40) +
                         num_runs * (TAPS + FRAME_ROWS * FRAME_COLS + 12) + 16;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_bit("o_valid after reset", o_valid, 1'b0);
    check_bit("o_done after reset", o_done, 1'b0);
    check_bit("o_busy after reset", o_busy, 1'b0);
    for (int r = 0; load_ok && r < num_runs; r++) begin
      // Frame stays stored when only the kernel changes.
      if (run_frame[r] != loaded) begin
        write_frame(run_frame[r]);
        loaded = run_frame[r];
      end
      write_coefs(run_set[r]);
      gap = $urandom_range(0, 7);
      repeat (gap) begin
        @(negedge clk);
        check_bit("o_valid between runs", o_valid, 1'b0);
        check_bit("o_done between runs", o_done, 1'b0);
        check_bit("o_busy between runs", o_busy, 1'b0);
      end
      run_frame_check(run_frame[r], run_set[r]);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("ALL CHECKS PASSED");
    else $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: files.f
source/conv_pkg.sv
source/frame_mem.sv
source/coef_bank.sv
source/window_ctrl.sv
source/window_5x5.sv
source/conv_mac.sv
source/conv5x5_top.sv
testbench/tb_conv5x5.sv

// File: testbench/conv5x5_stim.txt
# counts line: sets frames runs, then coefficient sets of 25 signed hex values (tap 0 first),
# then frames of 49 hex pixels in raster order, then one run per line as: frame set
3 2 5
03 fd 05 f9 02 fe 07 80 0b 01 f4 09 7f f7 06 04 fb 0a ff 08 f6 02 0d fc 05
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 02 03 04 05 06 07
10 11 12 13 14 15 16
20 21 22 23 24 25 26
30 31 32 33 34 35 36
40 41 42 43 44 45 46
50 51 52 53 54 55 56
60 61 62 63 64 65 66
ff 00 ff 80 7f ff 3c
a5 5a ff ff 01 c3 ff
00 ff 10 ee 99 ff 42
ff ff ff ff ff ff ff
7e 81 00 ff 33 cc 08
ff 20 ff 04 ff 6d ff
11 ff 87 ff 2b ff 00
0 0
0 1
0 2
1 2
1 0
